/* hw/scope_pkg.sv */
//////////////////////////////
// shared definitions for the scope trigger path
// sample and payload types, register map and reset values
// referenced by scoped name from RTL and testbench
//////////////////////////////

package scope_pkg;

  //////////////////////////////
  // sample stream
  //////////////////////////////

  // sample width in bits
  localparam int unsigned smp_w = 16;

  typedef logic signed [smp_w-1:0] sample_t;

  // hold-off counter width
  localparam int unsigned hld_w = 32;

  // stage-one payload, sample plus comparison flags
  typedef struct packed {
    sample_t smp;
    logic    below_neg;
    logic    above_pos;
  } sub_t;

  // output payload, sample plus trigger flag
  typedef struct packed {
    sample_t smp;
    logic    trig;
  } tag_t;

  //////////////////////////////
  // wishbone register map
  //////////////////////////////

  // word address width
  localparam int unsigned wb_aw = 3;

  localparam logic [wb_aw-1:0] addr_ctl = wb_aw'(0);
  localparam logic [wb_aw-1:0] addr_neg = wb_aw'(1);
  localparam logic [wb_aw-1:0] addr_pos = wb_aw'(2);
  localparam logic [wb_aw-1:0] addr_hld = wb_aw'(3);
  localparam logic [wb_aw-1:0] addr_cnt = wb_aw'(4);

  // reset values of the register bank
  localparam logic             rst_edg = 1'b0;
  localparam sample_t          rst_neg = sample_t'(0);
  localparam sample_t          rst_pos = sample_t'(0);
  localparam logic [hld_w-1:0] rst_hld = '0;
  localparam logic [31:0]      rst_cnt = '0;

endpackage

/* hw/stream_reg.sv */
//////////////////////////////
// one-deep valid/ready pipeline register
// payload type set by payload_t, adds one cycle of latency
//////////////////////////////

module stream_reg #(
  type payload_t = logic
) (
  input  logic     sti,
  input  logic     ctl_rst,
  // upstream side
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  // downstream side
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  // accept when downstream takes the current word or register is empty
  assign in_ready = out_ready | ~out_valid;

  //////////////////////////////
  // control
  //////////////////////////////

  // valid follows the upstream valid whenever the slot is free
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  //////////////////////////////
  // payload
  //////////////////////////////

  // load only on an upstream transfer
  always_ff @(posedge sti) begin
    if (in_valid && in_ready) begin
      out_data <= in_data;
    end
  end

  // stalled word stays put until the downstream takes it
  a_hold_stable : assert property (
    @(posedge sti) disable iff (ctl_rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
  ) else $error("stream_reg: payload changed while stalled");

endmodule

/* hw/scope_edge.sv */
//////////////////////////////
// edge detector with level hysteresis and hold-off
// stage one compares, stage two tags the trigger sample
//////////////////////////////

module scope_edge (
  input  logic                                sti,
  input  logic                                ctl_rst,
  // configuration from the register bank
  input  logic                                cfg_edg,
  input  scope_pkg::sample_t                  cfg_neg,
  input  scope_pkg::sample_t                  cfg_pos,
  input  logic [scope_pkg::hld_w-1:0]         cfg_hld,
  // sample stream in
  input  scope_pkg::sample_t                  smp_data,
  input  logic                                smp_valid,
  output logic                                smp_ready,
  // tagged stream out
  output scope_pkg::sample_t                  acq_data,
  output logic                                acq_trg,
  output logic                                acq_valid,
  input  logic                                acq_ready,
  // one pulse per trigger load
  output logic                                trg_evt
);

  // differences one bit wider than the sample
  logic [scope_pkg::smp_w:0]   sub_neg;
  logic [scope_pkg::smp_w:0]   sub_pos;
  scope_pkg::sub_t             cmp_in;
  scope_pkg::sub_t             cmp_out;
  logic                        cmp_valid;
  logic                        cmp_ready;
  // level state and hold-off counter
  logic                        lvl_s;
  logic                        lvl_nxt;
  logic                        lvl_set;
  logic                        lvl_clr;
  logic [scope_pkg::hld_w-1:0] hld_cnt;
  logic                        trig;
  logic                        trg_xfer;
  scope_pkg::tag_t             tag_in;
  scope_pkg::tag_t             tag_out;

  //////////////////////////////
  // compare stage
  //////////////////////////////

  // sign-extend both operands, sign bit of the difference is the flag
  assign sub_neg = {smp_data[scope_pkg::smp_w-1], smp_data}
                 - {cfg_neg[scope_pkg::smp_w-1], cfg_neg};
  assign sub_pos = {cfg_pos[scope_pkg::smp_w-1], cfg_pos}
                 - {smp_data[scope_pkg::smp_w-1], smp_data};

  assign cmp_in.smp       = smp_data;
  assign cmp_in.below_neg = sub_neg[scope_pkg::smp_w];
  assign cmp_in.above_pos = sub_pos[scope_pkg::smp_w];

  stream_reg #(.payload_t(scope_pkg::sub_t)) u_cmp (
    .sti      (sti),
    .ctl_rst  (ctl_rst),
    .in_data  (cmp_in),
    .in_valid (smp_valid),
    .in_ready (smp_ready),
    .out_data (cmp_out),
    .out_valid(cmp_valid),
    .out_ready(cmp_ready)
  );

  //////////////////////////////
  // trigger stage
  //////////////////////////////

  // falling edge swaps the roles of the two flags
  assign lvl_set = cfg_edg ? cmp_out.below_neg : cmp_out.above_pos;
  assign lvl_clr = cfg_edg ? cmp_out.above_pos : cmp_out.below_neg;
  assign lvl_nxt = lvl_s ? ~lvl_clr : lvl_set;

  // rising level state with no hold-off pending
  assign trig     = ~lvl_s & lvl_nxt & (hld_cnt == '0);
  assign trg_xfer = cmp_valid & cmp_ready;

  // state moves only when stage two loads, so stalls are harmless
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      lvl_s   <= 1'b0;
      hld_cnt <= '0;
      trg_evt <= 1'b0;
    end else begin
      trg_evt <= trg_xfer & trig;
      if (trg_xfer) begin
        lvl_s <= lvl_nxt;
        if (trig) begin
          hld_cnt <= cfg_hld;
        end else if (hld_cnt != '0) begin
          hld_cnt <= hld_cnt - 1'b1;
        end
      end
    end
  end

  assign tag_in.smp  = cmp_out.smp;
  assign tag_in.trig = trig;

  stream_reg #(.payload_t(scope_pkg::tag_t)) u_trg (
    .sti      (sti),
    .ctl_rst  (ctl_rst),
    .in_data  (tag_in),
    .in_valid (cmp_valid),
    .in_ready (cmp_ready),
    .out_data (tag_out),
    .out_valid(acq_valid),
    .out_ready(acq_ready)
  );

  assign acq_data = tag_out.smp;
  assign acq_trg  = tag_out.trig;

  // every trigger pulse sits on its tagged sample and reopens the hold-off window
  a_trg_hold : assert property (
    @(posedge sti) disable iff (ctl_rst)
    trg_evt |-> (acq_valid && acq_trg && (hld_cnt == $past(cfg_hld)))
  ) else $error("scope_edge: trigger pulse without tagged sample or hold-off load");

endmodule

/* hw/scope_regs.sv */
//////////////////////////////
// wishbone classic register bank
// edge select, levels, hold-off and trigger counter
// single accesses, one-cycle ack after the request
//////////////////////////////

module scope_regs (
  input  logic                                sti,
  input  logic                                ctl_rst,
  // wishbone classic slave
  input  logic                                wb_cyc,
  input  logic                                wb_stb,
  input  logic                                wb_we,
  input  logic [scope_pkg::wb_aw-1:0]         wb_adr,
  input  logic [31:0]                         wb_dat_w,
  output logic [31:0]                         wb_dat_r,
  output logic                                wb_ack,
  // trigger pulse from the edge detector
  input  logic                                trg_evt,
  // configuration levels
  output logic                                cfg_edg,
  output scope_pkg::sample_t                  cfg_neg,
  output scope_pkg::sample_t                  cfg_pos,
  output logic [scope_pkg::hld_w-1:0]         cfg_hld
);

  logic        req;
  logic        wr;
  logic        cnt_clr;
  logic [31:0] trg_cnt;
  logic [31:0] rd_mux;

  // new request only while ack is low
  assign req     = wb_cyc & wb_stb & ~wb_ack;
  assign wr      = req & wb_we;
  assign cnt_clr = wr && (wb_adr == scope_pkg::addr_cnt);

  //////////////////////////////
  // bus handshake
  //////////////////////////////

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req;
    end
  end

  //////////////////////////////
  // configuration registers
  //////////////////////////////

  // writes land on the same edge that raises ack
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      cfg_edg <= scope_pkg::rst_edg;
      cfg_neg <= scope_pkg::rst_neg;
      cfg_pos <= scope_pkg::rst_pos;
      cfg_hld <= scope_pkg::rst_hld;
    end else if (wr) begin
      case (wb_adr)
        scope_pkg::addr_ctl: cfg_edg <= wb_dat_w[0];
        scope_pkg::addr_neg: cfg_neg <= wb_dat_w[scope_pkg::smp_w-1:0];
        scope_pkg::addr_pos: cfg_pos <= wb_dat_w[scope_pkg::smp_w-1:0];
        scope_pkg::addr_hld: cfg_hld <= wb_dat_w[scope_pkg::hld_w-1:0];
        default: ;
      endcase
    end
  end

  // clear first, a trigger in the same cycle still counts
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      trg_cnt <= scope_pkg::rst_cnt;
    end else begin
      trg_cnt <= (cnt_clr ? 32'd0 : trg_cnt) + 32'(trg_evt);
    end
  end

  //////////////////////////////
  // read path
  //////////////////////////////

  // unmapped words read zero
  always_comb begin
    case (wb_adr)
      scope_pkg::addr_ctl: rd_mux = {31'd0, cfg_edg};
      scope_pkg::addr_neg: rd_mux = {16'd0, cfg_neg};
      scope_pkg::addr_pos: rd_mux = {16'd0, cfg_pos};
      scope_pkg::addr_hld: rd_mux = cfg_hld;
      scope_pkg::addr_cnt: rd_mux = trg_cnt;
      default:             rd_mux = 32'd0;
    endcase
  end

  // sampled with the request, valid while ack is high
  always_ff @(posedge sti) begin
    if (req) begin
      wb_dat_r <= rd_mux;
    end
  end

  // ack is a single-cycle pulse per access
  a_ack_pulse : assert property (
    @(posedge sti) disable iff (ctl_rst)
    wb_ack |=> !wb_ack
  ) else $error("scope_regs: ack held for two cycles");

endmodule

/* hw/scope_trigger_top.sv */
//////////////////////////////
// trigger path top level
// register bank drives the edge detector configuration
//////////////////////////////

module scope_trigger_top (
  input  logic                                sti,
  input  logic                                ctl_rst,
  // sample stream in
  input  scope_pkg::sample_t                  smp_data,
  input  logic                                smp_valid,
  output logic                                smp_ready,
  // tagged acquisition stream out
  output scope_pkg::sample_t                  acq_data,
  output logic                                acq_trg,
  output logic                                acq_valid,
  input  logic                                acq_ready,
  // wishbone classic slave
  input  logic                                wb_cyc,
  input  logic                                wb_stb,
  input  logic                                wb_we,
  input  logic [scope_pkg::wb_aw-1:0]         wb_adr,
  input  logic [31:0]                         wb_dat_w,
  output logic [31:0]                         wb_dat_r,
  output logic                                wb_ack
);

  // configuration and event wiring
  logic                        cfg_edg;
  scope_pkg::sample_t          cfg_neg;
  scope_pkg::sample_t          cfg_pos;
  logic [scope_pkg::hld_w-1:0] cfg_hld;
  logic                        trg_evt;

  //////////////////////////////
  // register bank
  //////////////////////////////

  scope_regs u_regs (
    .sti     (sti),
    .ctl_rst (ctl_rst),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_we   (wb_we),
    .wb_adr  (wb_adr),
    .wb_dat_w(wb_dat_w),
    .wb_dat_r(wb_dat_r),
    .wb_ack  (wb_ack),
    .trg_evt (trg_evt),
    .cfg_edg (cfg_edg),
    .cfg_neg (cfg_neg),
    .cfg_pos (cfg_pos),
    .cfg_hld (cfg_hld)
  );

  //////////////////////////////
  // edge detector
  //////////////////////////////

  scope_edge u_edge (
    .sti      (sti),
    .ctl_rst  (ctl_rst),
    .cfg_edg  (cfg_edg),
    .cfg_neg  (cfg_neg),
    .cfg_pos  (cfg_pos),
    .cfg_hld  (cfg_hld),
    .smp_data (smp_data),
    .smp_valid(smp_valid),
    .smp_ready(smp_ready),
    .acq_data (acq_data),
    .acq_trg  (acq_trg),
    .acq_valid(acq_valid),
    .acq_ready(acq_ready),
    .trg_evt  (trg_evt)
  );

endmodule

/* verif/tb_clk_rst.sv */
//////////////////////////////
// clock and reset source for the testbench
// sti at 40 ns period, ctl_rst high for the first 4 cycles
//////////////////////////////

module tb_clk_rst (
  output logic sti,
  output logic ctl_rst
);

  timeunit 1ns;
  timeprecision 100ps;

  // free-running clock
  initial begin
    sti = 1'b0;
    forever #20 sti = ~sti;
  end

  // release 2 ns after the fourth edge, like any other input
  initial begin
    ctl_rst = 1'b1;
    repeat (4) @(posedge sti);
    #2 ctl_rst = 1'b0;
  end

endmodule

/* verif/tb_scope_trigger.sv */
//////////////////////////////
// testbench for the scope trigger path
// wishbone register tests, trigger tests against a reference model
// output stream checked at the falling edge of sti
//////////////////////////////

module tb_scope_trigger;

  timeunit 1ns;
  timeprecision 100ps;

  logic                            sti;
  logic                            ctl_rst;
  scope_pkg::sample_t              smp_data;
  logic                            smp_valid;
  logic                            smp_ready;
  scope_pkg::sample_t              acq_data;
  logic                            acq_trg;
  logic                            acq_valid;
  logic                            acq_ready;
  logic                            wb_cyc;
  logic                            wb_stb;
  logic                            wb_we;
  logic [scope_pkg::wb_aw-1:0]     wb_adr;
  logic [31:0]                     wb_dat_w;
  logic [31:0]                     wb_dat_r;
  logic                            wb_ack;

  // configuration mirror and reference state
  logic                            m_edg = 1'b0;
  scope_pkg::sample_t              m_neg = '0;
  scope_pkg::sample_t              m_pos = '0;
  logic [31:0]                     m_hld = '0;
  logic                            ref_s = 1'b0;
  logic [31:0]                     ref_h = '0;
  scope_pkg::tag_t                 exp_q[$];
  scope_pkg::tag_t                 exp_tag;
  // bookkeeping
  integer                          seed = 32'hc3f;
  int                              n_sent = 0;
  int                              n_chk = 0;
  int                              n_err = 0;
  int                              err_mark = 0;
  int                              trg_seen = 0;
  int                              wd_cyc = 0;
  logic                            bp_on = 1'b0;
  logic [31:0]                     rd;

  tb_clk_rst u_clk (.sti(sti), .ctl_rst(ctl_rst));

  scope_trigger_top i_dut (
    .sti(sti), .ctl_rst(ctl_rst),
    .smp_data(smp_data), .smp_valid(smp_valid), .smp_ready(smp_ready),
    .acq_data(acq_data), .acq_trg(acq_trg), .acq_valid(acq_valid), .acq_ready(acq_ready),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
  );

  //////////////////////////////
  // reference model
  //////////////////////////////

  // one sample through hysteresis and hold-off
  function automatic logic ref_trig(input logic edg, input int neg, input int pos,
                                    input logic [31:0] hld, input logic s,
                                    input logic [31:0] h, input int smp,
                                    output logic s_n, output logic [31:0] h_n);
    logic below;
    logic above;
    logic t;
    below = smp < neg;
    above = smp > pos;
    // falling edge swaps which crossing arms and which one re-arms
    if (edg) s_n = s ? !above : below;
    else s_n = s ? !below : above;
    t = !s && s_n && (h == 0);
    if (t) h_n = hld;
    else if (h != 0) h_n = h - 1;
    else h_n = h;
    return t;
  endfunction

  //////////////////////////////
  // wishbone and stream tasks
  //////////////////////////////

  task automatic write_reg(input logic [scope_pkg::wb_aw-1:0] adr, input logic [31:0] d);
    @(posedge sti);
    #2;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = 1'b1;
    wb_adr = adr;
    wb_dat_w = d;
    do begin
      @(posedge sti);
      #1;
    end while (!wb_ack);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    // keep the model in step with the register map
    case (adr)
      scope_pkg::addr_ctl: m_edg = d[0];
      scope_pkg::addr_neg: m_neg = d[15:0];
      scope_pkg::addr_pos: m_pos = d[15:0];
      scope_pkg::addr_hld: m_hld = d;
      default: ;
    endcase
  endtask

  task automatic read_reg(input logic [scope_pkg::wb_aw-1:0] adr, output logic [31:0] d);
    @(posedge sti);
    #2;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_adr = adr;
    do begin
      @(posedge sti);
      #1;
    end while (!wb_ack);
    // data valid only while ack is up
    d = wb_dat_r;
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic expect_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_chk++;
    assert (got === exp) else begin
      $display("[ERROR] %s: got %h expected %h", name, got, exp);
      n_err++;
    end
  endtask

  task automatic check_reg(input logic [scope_pkg::wb_aw-1:0] adr, input logic [31:0] exp);
    read_reg(adr, rd);
    expect_word($sformatf("wb_dat_r[%0d]", adr), rd, exp);
  endtask

  // queue the expected tag, then offer the sample until it is taken
  task automatic send_sample(input int v);
    scope_pkg::sample_t smp;
    scope_pkg::tag_t    tag;
    logic               s_n;
    logic [31:0]        h_n;
    smp = scope_pkg::sample_t'(v);
    tag.smp = smp;
    tag.trig = ref_trig(m_edg, int'(m_neg), int'(m_pos), m_hld, ref_s, ref_h,
                        int'(smp), s_n, h_n);
    ref_s = s_n;
    ref_h = h_n;
    exp_q.push_back(tag);
    n_sent++;
    @(posedge sti);
    #2;
    smp_data = smp;
    smp_valid = 1'b1;
    do @(negedge sti); while (!smp_ready);
  endtask

  // one cycle with valid low
  task automatic idle_cycle();
    @(posedge sti);
    #2;
    smp_valid = 1'b0;
  endtask

  task automatic drain_stream();
    idle_cycle();
    while (exp_q.size() != 0) @(posedge sti);
  endtask

  // ramp up and down, then noise around each level in turn
  task automatic send_waves();
    int v;
    for (v = -300; v <= 300; v += 20) send_sample(v);
    for (v = 300; v >= -300; v -= 20) send_sample(v);
    for (int i = 0; i < 48; i++) begin
      v = ((i / 6) % 2) ? int'(m_pos) : int'(m_neg);
      send_sample(v + ($random(seed) % 64));
    end
  endtask

  task automatic send_square(input int n);
    for (int i = 0; i < n; i++) send_sample(((i / 2) % 2) ? 200 : -200);
  endtask

  task automatic report_test(input string name);
    if (n_err == err_mark) $display("test %s: ok", name);
    else $display("test %s: FAILED with %0d errors", name, n_err - err_mark);
    err_mark = n_err;
  endtask

  //////////////////////////////
  // output side
  //////////////////////////////

  // ready from the shared random source while back-pressure is on
  initial begin
    acq_ready = 1'b1;
    forever begin
      @(posedge sti);
      #2;
      acq_ready = bp_on ? (($random(seed) & 3) != 0) : 1'b1;
    end
  end

  // everything is settled at the falling edge
  always @(negedge sti) begin
    if (!ctl_rst && acq_valid && acq_ready) begin
      n_chk++;
      assert (exp_q.size() != 0) else begin
        $display("output transfer with no sample outstanding");
        n_err++;
      end
      if (exp_q.size() != 0) begin
        exp_tag = exp_q.pop_front();
        assert (acq_data === exp_tag.smp) else begin
          $display("[ERROR] acq_data: got %h expected %h", acq_data, exp_tag.smp);
          n_err++;
        end
        assert (acq_trg === exp_tag.trig) else begin
          $display("[ERROR] acq_trg: got %h expected %h", acq_trg, exp_tag.trig);
          n_err++;
        end
        // expected trigger count follows the reference tags
        if (exp_tag.trig) trg_seen++;
      end
      // a sample between the two levels can never complete an edge
      assert (!acq_trg || acq_data > m_pos || acq_data < m_neg) else begin
        $display("trigger on a sample between the levels");
        n_err++;
      end
    end
  end

  // limit grows with the number of samples sent
  initial begin
    while (wd_cyc <= 60 * n_sent + 200) begin
      @(posedge sti);
      wd_cyc++;
    end
    $display("run timed out after %0d cycles, %0d samples sent", wd_cyc, n_sent);
    $display("Some tests failed");
    $finish;
  end

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    smp_data = '0;
    smp_valid = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    wait (!ctl_rst);

    // reset values, then write and read back, unmapped word reads zero
    for (int a = 0; a < 5; a++) check_reg(a[2:0], 32'h0);
    write_reg(scope_pkg::addr_ctl, 32'hffff_ffff);
    check_reg(scope_pkg::addr_ctl, 32'h1);
    write_reg(scope_pkg::addr_neg, 32'h1234_8001);
    check_reg(scope_pkg::addr_neg, 32'h0000_8001);
    write_reg(scope_pkg::addr_pos, 32'h5555_7ffe);
    check_reg(scope_pkg::addr_pos, 32'h0000_7ffe);
    write_reg(scope_pkg::addr_hld, 32'hdead_beef);
    check_reg(scope_pkg::addr_hld, 32'hdead_beef);
    write_reg(scope_pkg::addr_cnt, 32'h5);
    check_reg(scope_pkg::addr_cnt, 32'h0);
    write_reg(3'd5, 32'hffff_ffff);
    check_reg(3'd5, 32'h0);
    report_test("register access");

    write_reg(scope_pkg::addr_ctl, 32'h0);
    write_reg(scope_pkg::addr_neg, 32'(-100));
    write_reg(scope_pkg::addr_pos, 32'd100);
    write_reg(scope_pkg::addr_hld, 32'd0);
    send_waves();
    drain_stream();
    report_test("rising edge");

    write_reg(scope_pkg::addr_ctl, 32'h1);
    send_waves();
    drain_stream();
    report_test("falling edge");

    write_reg(scope_pkg::addr_ctl, 32'h0);
    write_reg(scope_pkg::addr_hld, 32'd5);
    send_square(48);
    drain_stream();
    report_test("hold-off");

    // random samples with random gaps and random ready
    write_reg(scope_pkg::addr_hld, 32'd2);
    bp_on = 1'b1;
    for (int i = 0; i < 200; i++) begin
      if (($random(seed) & 3) == 0) idle_cycle();
      send_sample($random(seed) % 400);
    end
    drain_stream();
    bp_on = 1'b0;
    report_test("back-pressure");

    check_reg(scope_pkg::addr_cnt, 32'(trg_seen));
    write_reg(scope_pkg::addr_cnt, 32'h0);
    trg_seen = 0;
    check_reg(scope_pkg::addr_cnt, 32'h0);
    write_reg(scope_pkg::addr_hld, 32'd0);
    send_square(16);
    drain_stream();
    check_reg(scope_pkg::addr_cnt, 32'(trg_seen));
    report_test("trigger counter");

    $display("checks %0d, errors %0d", n_chk, n_err);
    if (n_err == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* scope_trigger.f */
hw/scope_pkg.sv
hw/stream_reg.sv
hw/scope_edge.sv
hw/scope_regs.sv
hw/scope_trigger_top.sv
verif/tb_clk_rst.sv
verif/tb_scope_trigger.sv

/* Bender.yml */
package:
  name: scope_trigger

sources:
  # RTL in compile order
  - files:
      - hw/scope_pkg.sv
      - hw/stream_reg.sv
      - hw/scope_edge.sv
      - hw/scope_regs.sv
      - hw/scope_trigger_top.sv
  # testbench
  - target: test
    files:
      - verif/tb_clk_rst.sv
      - verif/tb_scope_trigger.sv
